/* hdl/cmd_decode.sv */
`timescale 1ns/10ps

module cmd_decode (
  input  logic                 CLK,
  input  logic                 rst,
  input  stepper_pkg::word_t   word,
  input  logic                 word_valid,
  output stepper_pkg::status_t status,
  move_if.issuer               mv
);

  stepper_pkg::dec_state_t state;
  stepper_pkg::cmd_code_t  header;
  stepper_pkg::divisor_t   divisor;
  stepper_pkg::ustep_t     ustep;
  stepper_pkg::credit_t    credits;
  logic                    move_dir;
  logic                    overflow;  // Sticky until reset
  logic                    issue;

  assign header = stepper_pkg::cmd_code_t'(word[31:stepper_pkg::HDR_LSB]);
  assign issue  = word_valid && (state == stepper_pkg::DEC_DURATION) && (credits != '0);
  assign status = {overflow, 5'b0, credits};

  // Settings in force at issue travel with the request
  assign mv.req_divisor = divisor;
  assign mv.req_ustep   = ustep;
  assign mv.req_dir     = move_dir;

  always_ff @(posedge CLK) begin
    if (rst) begin
      state        <= stepper_pkg::DEC_HEADER;
      divisor      <= '0;
      ustep        <= '0;
      move_dir     <= 1'b0;
      overflow     <= 1'b0;
      mv.req_valid <= 1'b0;
    end else begin
      mv.req_valid <= issue;
      if (word_valid) begin
        if (state == stepper_pkg::DEC_HEADER) begin
          case (header)
            stepper_pkg::CMD_DIVISOR: divisor <= word[23:0];
            stepper_pkg::CMD_USTEP: begin
              if (word[23:0] > stepper_pkg::USTEP_MAX) begin
                ustep <= stepper_pkg::ustep_t'(stepper_pkg::USTEP_MAX);
              end else begin
                ustep <= word[1:0];
              end
            end
            stepper_pkg::CMD_MOVE: begin
              move_dir <= word[0];
              state    <= stepper_pkg::DEC_DURATION;
            end
            default: ;  // Unknown headers are ignored
          endcase
        end else begin
          if (!issue) overflow <= 1'b1;  // No credit, move dropped
          state <= stepper_pkg::DEC_HEADER;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (issue) mv.req_duration <= word;
  end

  // Credit counter
  always_ff @(posedge CLK) begin
    if (rst) begin
      credits <= stepper_pkg::credit_t'(stepper_pkg::QUEUE_DEPTH);
    end else begin
      credits <= credits - stepper_pkg::credit_t'(issue)
                         + stepper_pkg::credit_t'(mv.credit_return);
    end
  end

endmodule

/* hdl/move_if.sv */
`timescale 1ns/10ps

interface move_if;

  logic                   req_valid;      // One cycle per issued move
  stepper_pkg::duration_t req_duration;
  logic                   req_dir;
  stepper_pkg::divisor_t  req_divisor;
  stepper_pkg::ustep_t    req_ustep;
  logic                   credit_return;  // One cycle per finished move

  modport issuer (
    output req_valid, req_duration, req_dir, req_divisor, req_ustep,
    input  credit_return
  );

  modport queue (
    input  req_valid, req_duration, req_dir, req_divisor, req_ustep,
    output credit_return
  );

endinterface

/* hdl/phase_driver.sv */
`timescale 1ns/10ps

module phase_driver (
  input  logic                CLK,
  input  logic                rst,
  input  logic                step,
  input  logic                dir,
  input  stepper_pkg::ustep_t ustep,
  output logic                phase_a1,
  output logic                phase_a2,
  output logic                phase_b1,
  output logic                phase_b2,
  output logic                pwm_a,
  output logic                pwm_b
);

  stepper_pkg::elec_pos_t pos;
  stepper_pkg::elec_pos_t pos_inc;
  stepper_pkg::duty_t     pwm_cnt;
  logic [1:0]             quad;
  logic [2:0]             idx_a;
  logic [2:0]             idx_b;
  logic                   a_fwd;
  logic                   b_fwd;

  // Full step is 8 eighths, finer settings halve it
  assign pos_inc = stepper_pkg::elec_pos_t'(8) >> ustep;

  always_ff @(posedge CLK) begin
    if (rst) begin
      pos     <= '0;
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;  // Free running
      if (step) pos <= dir ? pos + pos_inc : pos - pos_inc;
    end
  end

  assign quad  = pos[4:3];
  assign a_fwd = (quad == 2'd0) || (quad == 2'd3);
  assign b_fwd = ~quad[1];

  assign phase_a1 = a_fwd;
  assign phase_a2 = ~a_fwd;
  assign phase_b1 = b_fwd;
  assign phase_b2 = ~b_fwd;

  // Coil A follows |cos|, coil B the mirrored entry
  assign idx_a = quad[0] ? ~pos[2:0] : pos[2:0];
  assign idx_b = ~idx_a;

  assign pwm_a = stepper_pkg::MAG_TABLE[idx_a] > pwm_cnt;
  assign pwm_b = stepper_pkg::MAG_TABLE[idx_b] > pwm_cnt;

endmodule

/* hdl/spi_word_rx.sv */
`timescale 1ns/10ps

module spi_word_rx (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 sck,
  input  logic                 ssel,
  input  logic                 mosi,
  output logic                 miso,
  input  stepper_pkg::status_t status,
  output stepper_pkg::word_t   word,
  output logic                 word_valid
);

  logic [2:0] sck_sync;   // Two sync stages and one edge history stage
  logic [1:0] ssel_sync;
  logic [1:0] mosi_sync;
  logic [2:0] bit_cnt;
  logic [1:0] byte_cnt;   // Byte lane within the word
  logic [6:0] rx_shift;
  logic [7:0] tx_shift;
  logic       sck_rise;
  logic       sck_fall;
  logic       ssel_idle;

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign ssel_idle = ssel_sync[1];
  assign miso      = tx_shift[7];  // MSB first

  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_sync  <= '0;
      ssel_sync <= '1;
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      ssel_sync <= {ssel_sync[0], ssel};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  // Bit and byte position, word strobe and status shifter
  always_ff @(posedge CLK) begin
    if (rst) begin
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      word_valid <= 1'b0;
      tx_shift   <= '0;
    end else begin
      word_valid <= 1'b0;
      if (ssel_idle) begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
        tx_shift <= status;  // Ready before the first rising edge
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            byte_cnt   <= byte_cnt + 2'd1;
            word_valid <= (byte_cnt == 2'd3);
          end
        end
        if (sck_fall) begin
          // Falling edge after a full byte starts the next byte
          if (bit_cnt == 3'd0) begin
            tx_shift <= status;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!ssel_idle && sck_rise) begin
      rx_shift <= {rx_shift[5:0], mosi_sync[1]};
      if (bit_cnt == 3'd7) begin
        word[8*byte_cnt +: 8] <= {rx_shift, mosi_sync[1]};  // Little endian lanes
      end
    end
  end

endmodule

/* hdl/step_gen.sv */
`timescale 1ns/10ps

module step_gen (
  input  logic                CLK,
  input  logic                rst,
  move_if.queue               mv,
  output logic                step,
  output logic                dir,
  output logic                busy,
  output stepper_pkg::ustep_t ustep
);

  stepper_pkg::duration_t q_dur [stepper_pkg::QUEUE_DEPTH];
  stepper_pkg::divisor_t  q_div [stepper_pkg::QUEUE_DEPTH];
  stepper_pkg::ustep_t    q_ust [stepper_pkg::QUEUE_DEPTH];
  logic                   q_dir [stepper_pkg::QUEUE_DEPTH];
  logic [stepper_pkg::QUEUE_PTR_W-1:0] wr_ptr;
  logic [stepper_pkg::QUEUE_PTR_W-1:0] rd_ptr;
  stepper_pkg::qcount_t   q_count;
  stepper_pkg::gen_state_t state;
  stepper_pkg::duration_t remain;   // Cycles left in the move
  stepper_pkg::divisor_t  divisor;
  stepper_pkg::divisor_t  div_cnt;
  logic                   pop;

  assign pop  = (state == stepper_pkg::GEN_IDLE) && (q_count != '0);
  assign busy = (remain != '0);  // Cycles remain only while a move runs
  assign step = (state == stepper_pkg::GEN_RUN) && (div_cnt == divisor);

  always_ff @(posedge CLK) begin
    if (mv.req_valid) begin
      q_dur[wr_ptr] <= mv.req_duration;
      q_div[wr_ptr] <= mv.req_divisor;
      q_ust[wr_ptr] <= mv.req_ustep;
      q_dir[wr_ptr] <= mv.req_dir;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (mv.req_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      q_count <= q_count + stepper_pkg::qcount_t'(mv.req_valid)
                         - stepper_pkg::qcount_t'(pop);
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state            <= stepper_pkg::GEN_IDLE;
      mv.credit_return <= 1'b0;
      remain           <= '0;
      divisor          <= '0;
      div_cnt          <= '0;
      dir              <= 1'b0;
      ustep            <= '0;
    end else begin
      mv.credit_return <= 1'b0;
      case (state)
        stepper_pkg::GEN_IDLE: begin
          if (pop) begin
            remain  <= q_dur[rd_ptr];
            divisor <= q_div[rd_ptr];
            ustep   <= q_ust[rd_ptr];
            dir     <= q_dir[rd_ptr];
            div_cnt <= '0;
            if (q_dur[rd_ptr] == '0) begin
              mv.credit_return <= 1'b1;  // Empty move ends at once
            end else begin
              state <= stepper_pkg::GEN_RUN;
            end
          end
        end
        stepper_pkg::GEN_RUN: begin
          remain  <= remain - 1'b1;
          div_cnt <= step ? '0 : div_cnt + 1'b1;
          if (remain == 32'd1) begin
            state            <= stepper_pkg::GEN_IDLE;
            mv.credit_return <= 1'b1;
          end
        end
        default: state <= stepper_pkg::GEN_IDLE;
      endcase
    end
  end

endmodule

/* hdl/stepper_pkg.sv */
package stepper_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] duration_t;    // Move length in CLK cycles
  typedef logic [23:0] divisor_t;     // Step every divisor+1 cycles
  typedef logic [1:0]  ustep_t;       // Microstep exponent, 2**ustep per full step
  typedef logic [4:0]  elec_pos_t;    // 32 eighth-steps per electrical cycle
  typedef logic [1:0]  credit_t;
  typedef logic [7:0]  status_t;      // {overflow, 5'b0, credits}

  // Header byte sits in the last byte of the word
  typedef enum logic [7:0] {
    CMD_MOVE    = 8'd1,
    CMD_DIVISOR = 8'd3,
    CMD_USTEP   = 8'd4
  } cmd_code_t;

  typedef enum logic {
    DEC_HEADER,
    DEC_DURATION
  } dec_state_t;

  typedef enum logic {
    GEN_IDLE,
    GEN_RUN
  } gen_state_t;

  localparam int HDR_LSB     = 24;
  localparam int USTEP_MAX   = 3;
  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int PWM_WIDTH   = 8;

  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] qcount_t;
  typedef logic [PWM_WIDTH-1:0] duty_t;

  // Coil magnitude, roughly 255*cos(i*pi/16)
  localparam duty_t MAG_TABLE [8] = '{8'd255, 8'd250, 8'd236, 8'd212,
                                      8'd180, 8'd142, 8'd98, 8'd50};

endpackage

/* hdl/stepper_top.sv */
`timescale 1ns/10ps

module stepper_top (
  input  logic CLK,
  input  logic rst,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic pwm_a,
  output logic pwm_b,
  output logic step,
  output logic dir,
  output logic busy
);

  stepper_pkg::word_t   word;
  logic                 word_valid;
  stepper_pkg::status_t status;
  stepper_pkg::ustep_t  ustep;

  move_if mv_bus ();

  spi_word_rx u_spi (
    .CLK(CLK), .rst(rst), .sck(sck), .ssel(ssel), .mosi(mosi), .miso(miso),
    .status(status), .word(word), .word_valid(word_valid)
  );

  cmd_decode u_dec (
    .CLK(CLK), .rst(rst), .word(word), .word_valid(word_valid),
    .status(status), .mv(mv_bus)
  );

  step_gen u_gen (
    .CLK(CLK), .rst(rst), .mv(mv_bus), .step(step), .dir(dir), .busy(busy),
    .ustep(ustep)
  );

  phase_driver u_phase (
    .CLK(CLK), .rst(rst), .step(step), .dir(dir), .ustep(ustep),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .pwm_a(pwm_a), .pwm_b(pwm_b)
  );

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module stepper_tb \
       -f verilog.f -o stepper_sim \
  && ./obj_dir/stepper_sim \
  || { echo "Simulation run failed"; exit 1; }

/* testbench/stepper_assertions.sv */
`timescale 1ns/10ps

module stepper_assertions (
  input logic                 CLK,
  input logic                 rst,
  input logic                 step,
  input logic                 busy,
  input logic                 credit_return,
  input stepper_pkg::qcount_t q_count
);

  a_step_in_move: assert property (@(posedge CLK) disable iff (rst) step |-> busy)
    else $error("step pulse outside of a move");

  // A finished move hands back exactly one credit
  a_credit_pulse: assert property (@(posedge CLK) disable iff (rst)
    credit_return |=> !credit_return)
    else $error("credit_return longer than one cycle");

  a_queue_depth: assert property (@(posedge CLK) disable iff (rst)
    q_count <= stepper_pkg::QUEUE_DEPTH)
    else $error("move queue holds more entries than its depth");

endmodule

bind step_gen stepper_assertions u_assert (
  .CLK(CLK), .rst(rst), .step(step), .busy(busy),
  .credit_return(mv.credit_return), .q_count(q_count)
);

/* testbench/stepper_tb.sv */
`timescale 1ns/10ps

module stepper_tb;

  localparam int SPI_HALF    = 4;                   // CLK cycles per SCK phase
  localparam int WORD_CYCLES = 64 * SPI_HALF + 2 * SPI_HALF;
  localparam int MAX_WORDS   = 100;                 // Upper bound on words sent
  localparam int N_SINGLE    = 10;
  localparam int N_MIX       = 8;
  localparam int N_PHASE_CHECKS = N_MIX + 2;
  localparam int PWM_PERIOD  = 2 ** stepper_pkg::PWM_WIDTH;
  localparam int LONG_MOVE   = 1600;
  localparam int SHORT_MOVE  = 200;
  localparam stepper_pkg::word_t NOP_WORD = 32'hFF00_0000;

  logic CLK, rst, sck, ssel, mosi, miso;
  logic phase_a1, phase_a2, phase_b1, phase_b2, pwm_a, pwm_b;
  logic step, dir, busy;

  // Expected moves in issue order, popped by the monitor
  stepper_pkg::duration_t exp_steps [$];
  stepper_pkg::duration_t exp_len [$];
  logic                   exp_dir [$];
  string                  exp_name [$];

  stepper_pkg::divisor_t  ref_div;
  stepper_pkg::ustep_t    ref_ustep;
  stepper_pkg::elec_pos_t ref_pos;
  stepper_pkg::duration_t run_len, run_steps;
  logic                   run_dir, busy_prev;
  string                  cur_name;
  int moves_sent, moves_done, pending_cycles, cycles, cycle_limit;

  stepper_pkg::divisor_t  s_div [N_SINGLE];
  stepper_pkg::duration_t s_dur [N_SINGLE];
  logic                   s_dir [N_SINGLE];
  stepper_pkg::divisor_t  m_div [N_MIX];
  stepper_pkg::duration_t m_dur [N_MIX];
  logic                   m_dir [N_MIX];
  logic [23:0]            m_ust [N_MIX];

  tb_clock clk_gen (.CLK(CLK));

  stepper_top uut (
    .CLK(CLK), .rst(rst), .sck(sck), .ssel(ssel), .mosi(mosi), .miso(miso),
    .phase_a1(phase_a1), .phase_a2(phase_a2), .phase_b1(phase_b1),
    .phase_b2(phase_b2), .pwm_a(pwm_a), .pwm_b(pwm_b),
    .step(step), .dir(dir), .busy(busy)
  );

  function automatic stepper_pkg::duration_t expected_steps(
    input stepper_pkg::duration_t d, input stepper_pkg::divisor_t div);
    return d / (stepper_pkg::duration_t'(div) + 32'd1);
  endfunction

  function automatic stepper_pkg::ustep_t clamp_ustep(input logic [23:0] v);
    return (v > 24'd3) ? 2'd3 : v[1:0];
  endfunction

  // Eighth steps per pulse shrink with finer microstepping
  function automatic stepper_pkg::elec_pos_t position_after(
    input stepper_pkg::elec_pos_t pos, input stepper_pkg::duration_t steps,
    input logic fwd, input stepper_pkg::ustep_t us);
    stepper_pkg::elec_pos_t delta;
    delta = stepper_pkg::elec_pos_t'(steps * (32'd8 >> us));
    if (fwd) begin
      return pos + delta;
    end else begin
      return pos - delta;
    end
  endfunction

  function automatic logic [1:0] expected_quadrant(input stepper_pkg::elec_pos_t pos);
    return pos[4:3];
  endfunction

  // Coil A walks down the table in even quadrants and back up in odd ones
  // Coil B takes the mirrored entry
  function automatic stepper_pkg::duty_t expected_duty(input stepper_pkg::elec_pos_t pos,
                                                       input logic coil_b);
    int offset;
    offset = pos % 8;
    if ((pos / 8) % 2 == 1) offset = 7 - offset;
    if (coil_b) offset = 7 - offset;
    return stepper_pkg::MAG_TABLE[offset];
  endfunction

  function automatic logic [1:0] quadrant_from_phases(input logic a_fwd, input logic b_fwd);
    case ({a_fwd, b_fwd})
      2'b11:   return 2'd0;
      2'b01:   return 2'd1;
      2'b00:   return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_count(input string name, input stepper_pkg::duration_t expected,
                             input stepper_pkg::duration_t actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual));
  endtask

  task automatic check_status(input string name, input stepper_pkg::status_t expected,
                              input stepper_pkg::status_t actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED %s: expected 0x%02h, actual 0x%02h",
                         name, expected, actual));
  endtask

  task automatic check_quad(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual));
  endtask

  task automatic check_duty(input string name, input stepper_pkg::duty_t expected,
                            input stepper_pkg::duty_t actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual));
  endtask

  task automatic check_dir(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      fail_run($sformatf("CHECK FAILED %s: expected %0b, actual %0b", name, expected, actual));
  endtask

  // One SPI frame, MSB first per byte; first MISO byte is the status
  task automatic spi_transfer(input stepper_pkg::word_t w, output stepper_pkg::status_t st);
    ssel = 1'b0;
    for (int i = 0; i < 32; i++) begin
      mosi = w[8 * (i / 8) + 7 - (i % 8)];
      repeat (SPI_HALF) @(negedge CLK);
      if (i < 8) st[7 - i] = miso;
      sck = 1'b1;
      repeat (SPI_HALF) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (SPI_HALF) @(negedge CLK);
    ssel = 1'b1;
    repeat (SPI_HALF) @(negedge CLK);
  endtask

  task automatic send_word(input stepper_pkg::word_t w);
    stepper_pkg::status_t ignored;
    spi_transfer(w, ignored);
  endtask

  task automatic read_status(input string name, input stepper_pkg::status_t expected);
    stepper_pkg::status_t st;
    spi_transfer(NOP_WORD, st);
    check_status(name, expected, st);
  endtask

  task automatic set_divisor(input stepper_pkg::divisor_t d);
    send_word({stepper_pkg::CMD_DIVISOR, d});
    ref_div = d;
  endtask

  task automatic set_ustep(input logic [23:0] v);
    send_word({stepper_pkg::CMD_USTEP, v});
    ref_ustep = clamp_ustep(v);
  endtask

  // Expectations go in first, a one cycle move can end as the frame closes
  task automatic issue_move(input string name, input stepper_pkg::duration_t d,
                            input logic fwd, input logic dropped);
    stepper_pkg::duration_t steps;
    steps = expected_steps(d, ref_div);
    if (!dropped) begin
      ref_pos = position_after(ref_pos, steps, fwd, ref_ustep);
      pending_cycles += d;
      if (d != 0) begin
        exp_steps.push_back(steps);
        exp_len.push_back(d);
        exp_dir.push_back(fwd);
        exp_name.push_back(name);
        moves_sent++;
      end
    end
    send_word({stepper_pkg::CMD_MOVE, 23'd0, fwd});
    send_word(d);
  endtask

  task automatic wait_moves();
    int waited;
    waited = 0;
    while (moves_done != moves_sent && waited < pending_cycles + 100) begin
      @(negedge CLK);
      waited++;
    end
    if (moves_done != moves_sent)
      fail_run($sformatf("Moves did not finish after %0d cycles, busy never rose or stuck",
                         waited));
    pending_cycles = 0;
    repeat (4) @(negedge CLK);  // Position settles after the last step
  endtask

  // A full PWM period sweeps the counter through every value once
  task automatic check_pwm(input string name);
    int high_a;
    int high_b;
    high_a = 0;
    high_b = 0;
    repeat (PWM_PERIOD) begin
      @(negedge CLK);
      if (pwm_a) high_a++;
      if (pwm_b) high_b++;
    end
    check_duty({name, " pwm_a"}, expected_duty(ref_pos, 1'b0),
               stepper_pkg::duty_t'(high_a));
    check_duty({name, " pwm_b"}, expected_duty(ref_pos, 1'b1),
               stepper_pkg::duty_t'(high_b));
  endtask

  task automatic check_phases(input string name);
    if (phase_a2 !== ~phase_a1 || phase_b2 !== ~phase_b1)
      fail_run($sformatf("Coil outputs are not complementary in %s", name));
    check_quad(name, expected_quadrant(ref_pos), quadrant_from_phases(phase_a1, phase_b1));
    check_pwm(name);
  endtask

  // Measures every move on the step outputs and compares at the end of busy
  always @(negedge CLK) begin
    if (rst) begin
      run_len   = '0;
      run_steps = '0;
      busy_prev = 1'b0;
    end else begin
      if (busy) begin
        run_len = run_len + 1;
        if (step) run_steps = run_steps + 1;
        run_dir = dir;
      end else if (busy_prev) begin
        if (exp_len.size() == 0) fail_run("A move ran that should have been dropped");
        cur_name = exp_name.pop_front();
        check_count({cur_name, " busy cycles"}, exp_len.pop_front(), run_len);
        check_count({cur_name, " steps"}, exp_steps.pop_front(), run_steps);
        check_dir({cur_name, " dir"}, exp_dir.pop_front(), run_dir);
        moves_done++;
        run_len   = '0;
        run_steps = '0;
      end
      busy_prev = busy;
    end
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) fail_run("Timeout, the run exceeded its cycle limit");
  end

  initial begin
    rst = 1'b1;
    sck = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    ref_div = '0;
    ref_ustep = '0;
    ref_pos = '0;
    void'($urandom(63));
    cycle_limit = 2 * LONG_MOVE + 2 * SHORT_MOVE + 300 + 250 + MAX_WORDS * WORD_CYCLES
                  + N_PHASE_CHECKS * PWM_PERIOD + 2000;
    for (int i = 0; i < N_SINGLE; i++) begin
      s_div[i] = $urandom_range(30, 0);
      s_dur[i] = $urandom_range(400, 0);
      s_dir[i] = $urandom_range(1, 0);
    end
    s_dur[0] = '0;  // Empty move
    for (int i = 0; i < N_MIX; i++) begin
      m_div[i] = $urandom_range(30, 0);
      m_dur[i] = $urandom_range(400, 0);
      m_dir[i] = $urandom_range(1, 0);
      m_ust[i] = $urandom_range(5, 0);
    end
    m_ust[0] = 24'd5;  // Clamped to 3
    for (int i = 0; i < N_SINGLE; i++) cycle_limit += s_dur[i];
    for (int i = 0; i < N_MIX; i++) cycle_limit += m_dur[i];
    repeat (10) @(negedge CLK);
    rst = 1'b0;
    @(negedge CLK);

    if (busy !== 1'b0 || step !== 1'b0) fail_run("busy or step is high after reset");
    read_status("status after reset", 8'h02);

    for (int i = 0; i < N_SINGLE; i++) begin
      set_divisor(s_div[i]);
      issue_move($sformatf("single move %0d", i), s_dur[i], s_dir[i], 1'b0);
      wait_moves();
    end
    read_status("status after single moves", 8'h02);

    // Divisor changes while the first move runs
    set_divisor(24'd5);
    issue_move("back to back first", LONG_MOVE, 1'b1, 1'b0);
    read_status("one credit in use", 8'h01);
    set_divisor(24'd13);
    issue_move("back to back second", SHORT_MOVE, 1'b0, 1'b0);
    read_status("both credits in use", 8'h00);
    wait_moves();
    read_status("credits recovered", 8'h02);

    set_divisor(24'd7);
    issue_move("full queue first", LONG_MOVE, 1'b1, 1'b0);
    issue_move("full queue second", SHORT_MOVE, 1'b1, 1'b0);
    issue_move("full queue third", 300, 1'b0, 1'b1);
    read_status("overflow after dropped move", 8'h80);
    wait_moves();
    read_status("overflow is sticky", 8'h82);
    check_phases("quadrant after full queue");

    for (int i = 0; i < N_MIX; i++) begin
      set_ustep(m_ust[i]);
      set_divisor(m_div[i]);
      issue_move($sformatf("mixed move %0d", i), m_dur[i], m_dir[i], 1'b0);
      wait_moves();
      check_phases($sformatf("quadrant after mixed move %0d", i));
    end

    set_divisor(24'd9);
    send_word({8'h02, 24'h000123});
    send_word({8'h05, 24'hFFFFFF});
    send_word({8'hA5, 24'($urandom())});
    issue_move("move after unknown headers", 250, 1'b1, 1'b0);
    wait_moves();
    read_status("status after unknown headers", 8'h82);
    check_phases("quadrant after unknown headers");

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;  // 10 ns period
  end

endmodule

/* verilog.f */
hdl/stepper_pkg.sv
hdl/move_if.sv
hdl/spi_word_rx.sv
hdl/cmd_decode.sv
hdl/step_gen.sv
hdl/phase_driver.sv
hdl/stepper_top.sv
testbench/tb_clock.sv
testbench/stepper_assertions.sv
testbench/stepper_tb.sv
